/* compile.f */
+incdir+rtl
rtl/ss_pkg.sv
rtl/ss_decode.sv
rtl/ss_execute.sv
rtl/ss_result.sv
rtl/shortstack_top.sv
sim/shortstack_assertions.sv
sim/shortstack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the short-stack testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module shortstack_tb -o shortstack_sim

./obj_dir/shortstack_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

/* sim/shortstack_tb.sv */
/*
  Short-stack unit testbench
  Directed tests for LIFO pops, stack overflow, restart, total miss,
  input priority and result back-pressure, with a result monitor
*/
`timescale 1ns/100ps
`default_nettype none

module shortstack_tb import shortstack_pkg::*; ();

  localparam int TIMEOUT   = 200;
  localparam int SRC_PUSH  = 0;
  localparam int SRC_REST  = 1;
  localparam int SRC_SCENE = 2;
  localparam int SRC_MISS  = 3;

  logic     clk;
  logic     rst_n;
  logic     push_valid;
  ray_id_t  push_ray_id;
  node_id_t push_node_id;
  t_val_t   push_t_max;
  logic     push_stall;
  logic     rest_valid;
  ray_id_t  rest_ray_id;
  node_id_t rest_node_id;
  t_val_t   rest_t_max;
  logic     rest_stall;
  logic     scene_valid;
  ray_id_t  scene_ray_id;
  t_val_t   scene_t_max;
  logic     scene_stall;
  logic     miss_valid;
  ray_id_t  miss_ray_id;
  t_val_t   miss_t_max;
  logic     miss_stall;
  logic     tarb_valid;
  ray_id_t  tarb_ray_id;
  node_id_t tarb_node_id;
  t_val_t   tarb_t_max;
  t_val_t   tarb_t_min;
  logic     tarb_restart;
  logic     tarb_stall;
  logic     shader_valid;
  ray_id_t  shader_ray_id;
  logic     shader_stall;

  integer seed     = 32'h1683_ef18;
  int     checks   = 0;
  int     errors   = 0;
  int     timeouts = 0;
  logic   was_stalled [4] = '{default: 1'b0};

  // Results taken off tarb and shader in transfer order
  ss_res_e  got_kind [$];
  ray_id_t  got_ray  [$];
  node_id_t got_node [$];
  t_val_t   got_tmax [$];
  t_val_t   got_tmin [$];

  shortstack_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //----------------------------------------------------------------------
  // Result monitor with one entry per transfer
  //----------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst_n && tarb_valid && !tarb_stall) begin
      if (tarb_restart) begin
        got_kind.push_back(RES_RESTART);
      end else begin
        got_kind.push_back(RES_POP);
      end
      got_ray.push_back(tarb_ray_id);
      got_node.push_back(tarb_node_id);
      got_tmax.push_back(tarb_t_max);
      got_tmin.push_back(tarb_t_min);
    end else if (rst_n && shader_valid && !shader_stall) begin
      got_kind.push_back(RES_MISS);
      got_ray.push_back(shader_ray_id);
      got_node.push_back('0);
      got_tmax.push_back('0);
      got_tmin.push_back('0);
    end
  end

  //----------------------------------------------------------------------
  // Run control and compares
  //----------------------------------------------------------------------

  function automatic logic [31:0] draw();
    return $random(seed);
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    timeouts++;
    $display("timeout at %0t ns: %s", $time, what);
    finish_run();
  endtask

  task automatic kind_check(input ss_res_e got, input ss_res_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s kind %s, expected %s",
               $time, what, got.name(), exp.name());
    end
  endtask

  task automatic ray_check(input ray_id_t got, input ray_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s ray %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic node_check(input node_id_t got, input node_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s node %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic t_check(input t_val_t got, input t_val_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_results(input string what);
    int n;
    n = 0;
    while (got_kind.size() == 0) begin
      n++;
      if (n > TIMEOUT) begin
        timeout_abort({"no result arrived for ", what});
      end
      @(negedge clk);
    end
  endtask

  task automatic result_check(input ss_res_e kind, input ray_id_t ray, input node_id_t node,
                              input t_val_t tmax, input t_val_t tmin, input string what);
    ss_res_e  k;
    ray_id_t  r;
    node_id_t nd;
    t_val_t   mx;
    t_val_t   mn;
    wait_results(what);
    k  = got_kind.pop_front();
    r  = got_ray.pop_front();
    nd = got_node.pop_front();
    mx = got_tmax.pop_front();
    mn = got_tmin.pop_front();
    kind_check(k, kind, what);
    ray_check(r, ray, what);
    // A total miss carries only its ray ID
    if (kind != RES_MISS) begin
      node_check(nd, node, what);
      t_check(mx, tmax, {what, " t_max"});
      t_check(mn, tmin, {what, " t_min"});
    end
  endtask

  task automatic idle_check(input string what);
    repeat (8) @(negedge clk);
    if (got_kind.size() != 0) begin
      errors++;
      $display("%0d unexpected extra results after %s", got_kind.size(), what);
      got_kind.delete();
      got_ray.delete();
      got_node.delete();
      got_tmax.delete();
      got_tmin.delete();
    end
  endtask

  //----------------------------------------------------------------------
  // Input handshakes
  //----------------------------------------------------------------------

  function automatic logic stalled(input int src);
    case (src)
      SRC_PUSH:  return push_stall;
      SRC_REST:  return rest_stall;
      SRC_SCENE: return scene_stall;
      default:   return miss_stall;
    endcase
  endfunction

  task automatic drop_valid(input int src);
    case (src)
      SRC_PUSH:  push_valid = 1'b0;
      SRC_REST:  rest_valid = 1'b0;
      SRC_SCENE: scene_valid = 1'b0;
      default:   miss_valid = 1'b0;
    endcase
  endtask

  // Stall settles within 1 ns of the falling-edge drive
  task automatic wait_accept(input int src, input string what);
    int n;
    n = 0;
    #1;
    while (stalled(src)) begin
      was_stalled[src] = 1'b1;
      n++;
      if (n > TIMEOUT) begin
        timeout_abort(what);
      end
      @(negedge clk);
      #1;
    end
    // Taken on the rising edge in between
    @(negedge clk);
    drop_valid(src);
  endtask

  task automatic push_node(input ray_id_t ray, input node_id_t node, input t_val_t t);
    @(negedge clk);
    push_valid   = 1'b1;
    push_ray_id  = ray;
    push_node_id = node;
    push_t_max   = t;
    wait_accept(SRC_PUSH, "push was never accepted");
  endtask

  task automatic write_restart(input ray_id_t ray, input node_id_t node, input t_val_t t);
    @(negedge clk);
    rest_valid   = 1'b1;
    rest_ray_id  = ray;
    rest_node_id = node;
    rest_t_max   = t;
    wait_accept(SRC_REST, "restart write was never accepted");
  endtask

  task automatic write_scene(input ray_id_t ray, input t_val_t t);
    @(negedge clk);
    scene_valid  = 1'b1;
    scene_ray_id = ray;
    scene_t_max  = t;
    wait_accept(SRC_SCENE, "scene write was never accepted");
  endtask

  task automatic issue_miss(input ray_id_t ray, input t_val_t leaf);
    @(negedge clk);
    miss_valid  = 1'b1;
    miss_ray_id = ray;
    miss_t_max  = leaf;
    wait_accept(SRC_MISS, "leaf miss was never accepted");
  endtask

  //----------------------------------------------------------------------
  // Directed tests
  //----------------------------------------------------------------------

  task automatic test_lifo();
    node_id_t a, b;
    t_val_t   ta, tb, l1, l2;
    a  = node_id_t'(draw());
    b  = node_id_t'(draw());
    ta = t_val_t'(draw());
    tb = t_val_t'(draw());
    l1 = t_val_t'(draw());
    l2 = t_val_t'(draw());
    push_node(4'd1, a, ta);
    push_node(4'd1, b, tb);
    issue_miss(4'd1, l1);
    issue_miss(4'd1, l2);
    result_check(RES_POP, 4'd1, b, tb, l1, "lifo newest");
    result_check(RES_POP, 4'd1, a, ta, l2, "lifo oldest");
    idle_check("lifo");
  endtask

  task automatic test_overflow();
    node_id_t nodes [5];
    t_val_t   tms   [5];
    t_val_t   leaves [5];
    node_id_t rnode;
    rnode = node_id_t'(draw());
    write_scene(4'd2, 16'hf000);
    write_restart(4'd2, rnode, t_val_t'(draw()));
    for (int i = 0; i < 5; i++) begin
      nodes[i]  = node_id_t'(draw());
      tms[i]    = t_val_t'(draw());
      leaves[i] = t_val_t'(draw()) & 16'h0fff;
      push_node(4'd2, nodes[i], tms[i]);
    end
    for (int i = 0; i < 5; i++) begin
      issue_miss(4'd2, leaves[i]);
    end
    // Oldest push was overwritten by the fifth
    for (int i = 0; i < 4; i++) begin
      result_check(RES_POP, 4'd2, nodes[4-i], tms[4-i], leaves[i], "overflow pop");
    end
    result_check(RES_RESTART, 4'd2, rnode, 16'hf000, leaves[4], "overflow restart");
    idle_check("overflow");
  endtask

  task automatic test_restart();
    t_val_t   s, leaf, rt;
    node_id_t r;
    s    = t_val_t'(draw()) | 16'h8000;
    leaf = t_val_t'(draw()) & 16'h7fff;
    r    = node_id_t'(draw());
    rt   = t_val_t'(draw());
    was_stalled[SRC_REST]  = 1'b0;
    was_stalled[SRC_SCENE] = 1'b0;
    // Restart write outranks the scene write in the same cycle
    fork
      write_scene(4'd3, s);
      write_restart(4'd3, r, rt);
    join
    if (!was_stalled[SRC_SCENE]) begin
      errors++;
      $display("scene write was not stalled behind a restart write in the same cycle");
    end
    if (was_stalled[SRC_REST]) begin
      errors++;
      $display("restart write was stalled with only a scene write competing");
    end
    issue_miss(4'd3, leaf);
    result_check(RES_RESTART, 4'd3, r, s, leaf, "restart");
    idle_check("restart");
  endtask

  task automatic test_total_miss();
    t_val_t s, leaf;
    s    = t_val_t'(draw()) & 16'h7fff;
    leaf = s + (t_val_t'(draw()) & 16'h00ff);
    write_scene(4'd4, s);
    issue_miss(4'd4, leaf);
    result_check(RES_MISS, 4'd4, '0, '0, '0, "total miss");
    idle_check("total miss");
  endtask

  task automatic test_priority();
    node_id_t a, b, rn;
    t_val_t   ta, tb, l1, l2, rt;
    a  = node_id_t'(draw());
    b  = node_id_t'(draw());
    ta = t_val_t'(draw());
    tb = t_val_t'(draw());
    l1 = t_val_t'(draw());
    l2 = t_val_t'(draw());
    rn = node_id_t'(draw());
    rt = t_val_t'(draw());
    push_node(4'd5, a, ta);
    was_stalled[SRC_PUSH] = 1'b0;
    was_stalled[SRC_REST] = 1'b0;
    fork
      issue_miss(4'd5, l1);
      push_node(4'd5, b, tb);
      write_restart(4'd5, rn, rt);
    join
    if (!was_stalled[SRC_PUSH]) begin
      errors++;
      $display("push was not stalled while a miss arrived in the same cycle");
    end
    if (!was_stalled[SRC_REST]) begin
      errors++;
      $display("restart write was not stalled behind a miss and a push");
    end
    result_check(RES_POP, 4'd5, a, ta, l1, "priority old top");
    issue_miss(4'd5, l2);
    result_check(RES_POP, 4'd5, b, tb, l2, "priority late push");
    idle_check("priority");
  endtask

  task automatic test_backpressure();
    ray_id_t  rays   [6];
    node_id_t nodes  [6];
    t_val_t   tms    [6];
    t_val_t   leaves [6];
    logic     used   [16];
    ray_id_t  r;
    int       n;
    for (int i = 0; i < 16; i++) begin
      used[i] = 1'b0;
    end
    // One entry on each of six distinct rays
    for (int i = 0; i < 6; i++) begin
      r = ray_id_t'(draw());
      while (used[r]) begin
        r = r + 1'b1;
      end
      used[r]   = 1'b1;
      rays[i]   = r;
      nodes[i]  = node_id_t'(draw());
      tms[i]    = t_val_t'(draw());
      leaves[i] = t_val_t'(draw());
      push_node(rays[i], nodes[i], tms[i]);
    end
    @(negedge clk);
    tarb_stall = 1'b1;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          issue_miss(rays[i], leaves[i]);
        end
      end
      begin
        n = 0;
        @(negedge clk);
        #1;
        while (!miss_stall) begin
          n++;
          if (n > TIMEOUT) begin
            timeout_abort("miss_stall never rose under tarb back-pressure");
          end
          @(negedge clk);
          #1;
        end
        repeat (3) @(negedge clk);
        tarb_stall = 1'b0;
      end
    join
    for (int i = 0; i < 6; i++) begin
      result_check(RES_POP, rays[i], nodes[i], tms[i], leaves[i], "back-pressure");
    end
    idle_check("back-pressure");
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------

  initial begin
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_ray_id  = '0;
    push_node_id = '0;
    push_t_max   = '0;
    rest_valid   = 1'b0;
    rest_ray_id  = '0;
    rest_node_id = '0;
    rest_t_max   = '0;
    scene_valid  = 1'b0;
    scene_ray_id = '0;
    scene_t_max  = '0;
    miss_valid   = 1'b0;
    miss_ray_id  = '0;
    miss_t_max   = '0;
    tarb_stall   = 1'b0;
    shader_stall = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_lifo();
    test_overflow();
    test_restart();
    test_total_miss();
    test_priority();
    test_backpressure();
    finish_run();
  end

endmodule

`default_nettype wire

/* sim/shortstack_assertions.sv */
/*
  Short-stack output assertions
  Checks that tarb and shader never fire together, that a stalled
  output holds, and that outputs are idle right after reset
*/
`timescale 1ns/100ps
`default_nettype none

module shortstack_assertions import shortstack_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     tarb_valid,
  input logic     tarb_stall,
  input ray_id_t  tarb_ray_id,
  input node_id_t tarb_node_id,
  input t_val_t   tarb_t_max,
  input t_val_t   tarb_t_min,
  input logic     tarb_restart,
  input logic     shader_valid,
  input logic     shader_stall,
  input ray_id_t  shader_ray_id
);

  // One ordered queue, so one head and one output
  a_one_output: assert property (@(posedge clk) disable iff (!rst_n)
    !(tarb_valid && shader_valid))
    else $error("tarb_valid and shader_valid high together");

  a_tarb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    tarb_valid && tarb_stall |=> tarb_valid &&
      $stable({tarb_ray_id, tarb_node_id, tarb_t_max, tarb_t_min, tarb_restart}))
    else $error("tarb output changed while stalled");

  a_shader_hold: assert property (@(posedge clk) disable iff (!rst_n)
    shader_valid && shader_stall |=> shader_valid && $stable(shader_ray_id))
    else $error("shader output changed while stalled");

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !tarb_valid && !shader_valid)
    else $error("output valid in the cycle after reset");

endmodule

bind shortstack_top shortstack_assertions u_assertions (
  .clk, .rst_n,
  .tarb_valid, .tarb_stall, .tarb_ray_id, .tarb_node_id,
  .tarb_t_max, .tarb_t_min, .tarb_restart,
  .shader_valid, .shader_stall, .shader_ray_id
);

`default_nettype wire

/* rtl/shortstack_top.sv */
/*
  Short-stack unit
  Per-ray pending-node stack with restart and scene-exit tables,
  built as decode, execute and result stages
*/
`timescale 1ns/100ps
`default_nettype none

module shortstack_top import shortstack_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  input  ray_id_t  push_ray_id,
  input  node_id_t push_node_id,
  input  t_val_t   push_t_max,
  output logic     push_stall,
  input  logic     rest_valid,
  input  ray_id_t  rest_ray_id,
  input  node_id_t rest_node_id,
  input  t_val_t   rest_t_max,
  output logic     rest_stall,
  input  logic     scene_valid,
  input  ray_id_t  scene_ray_id,
  input  t_val_t   scene_t_max,
  output logic     scene_stall,
  input  logic     miss_valid,
  input  ray_id_t  miss_ray_id,
  input  t_val_t   miss_t_max,
  output logic     miss_stall,
  output logic     tarb_valid,
  output ray_id_t  tarb_ray_id,
  output node_id_t tarb_node_id,
  output t_val_t   tarb_t_max,
  output t_val_t   tarb_t_min,
  output logic     tarb_restart,
  input  logic     tarb_stall,
  output logic     shader_valid,
  output ray_id_t  shader_ray_id,
  input  logic     shader_stall
);

  // Decode to execute
  ss_op_e   op;
  ray_id_t  op_ray_id;
  node_id_t op_node_id;
  t_val_t   op_t_max;

  // Execute to result
  logic     rd_valid;
  ss_res_e  rd_kind;
  ray_id_t  rd_ray_id;
  node_id_t rd_node_id;
  t_val_t   rd_t_max;
  t_val_t   rd_t_min;

  logic     pop_room;

  ss_decode u_decode (
    .clk, .rst_n,
    .push_valid, .push_ray_id, .push_node_id, .push_t_max, .push_stall,
    .rest_valid, .rest_ray_id, .rest_node_id, .rest_t_max, .rest_stall,
    .scene_valid, .scene_ray_id, .scene_t_max, .scene_stall,
    .miss_valid, .miss_ray_id, .miss_t_max, .miss_stall,
    .pop_room,
    .op, .op_ray_id, .op_node_id, .op_t_max
  );

  ss_execute u_execute (
    .clk, .rst_n,
    .op, .op_ray_id, .op_node_id, .op_t_max,
    .rd_valid, .rd_kind, .rd_ray_id, .rd_node_id, .rd_t_max, .rd_t_min
  );

  ss_result u_result (
    .clk, .rst_n,
    .rd_valid, .rd_kind, .rd_ray_id, .rd_node_id, .rd_t_max, .rd_t_min,
    .tarb_stall, .shader_stall,
    .pop_room,
    .tarb_valid, .tarb_ray_id, .tarb_node_id, .tarb_t_max, .tarb_t_min,
    .tarb_restart,
    .shader_valid, .shader_ray_id
  );

endmodule

`default_nettype wire

/* rtl/ss_result.sv */
/*
  Short-stack result stage
  Four-entry ordered queue of leaf-miss outcomes. The head goes to
  tarb for pops and restarts, or to the shader for total misses
*/
`timescale 1ns/100ps
`default_nettype none

`include "ss_params.svh"

module ss_result import shortstack_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rd_valid,
  input  ss_res_e  rd_kind,
  input  ray_id_t  rd_ray_id,
  input  node_id_t rd_node_id,
  input  t_val_t   rd_t_max,
  input  t_val_t   rd_t_min,
  input  logic     tarb_stall,
  input  logic     shader_stall,
  output logic     pop_room,
  output logic     tarb_valid,
  output ray_id_t  tarb_ray_id,
  output node_id_t tarb_node_id,
  output t_val_t   tarb_t_max,
  output t_val_t   tarb_t_min,
  output logic     tarb_restart,
  output logic     shader_valid,
  output ray_id_t  shader_ray_id
);

  localparam int QDEPTH = `SS_RES_FIFO_DEPTH;
  localparam int QPTR_W = $clog2(QDEPTH);

  ss_res_e  q_kind [QDEPTH];
  ray_id_t  q_ray  [QDEPTH];
  node_id_t q_node [QDEPTH];
  t_val_t   q_tmax [QDEPTH];
  t_val_t   q_tmin [QDEPTH];

  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QPTR_W:0]   count;
  logic              not_empty;
  logic              head_pop;
  ss_res_e           head_kind;

  //----------------------------------------------------------------------
  // Head routing
  //----------------------------------------------------------------------

  assign not_empty = (count != '0);
  assign head_kind = q_kind[rd_ptr];

  assign tarb_valid    = not_empty && (head_kind != RES_MISS);
  assign tarb_ray_id   = q_ray[rd_ptr];
  assign tarb_node_id  = q_node[rd_ptr];
  assign tarb_t_max    = q_tmax[rd_ptr];
  assign tarb_t_min    = q_tmin[rd_ptr];
  assign tarb_restart  = (head_kind == RES_RESTART);
  assign shader_valid  = not_empty && (head_kind == RES_MISS);
  assign shader_ray_id = q_ray[rd_ptr];

  // A stalled head blocks both outputs
  assign head_pop = (tarb_valid && !tarb_stall) || (shader_valid && !shader_stall);

  // Room for two misses in flight plus a new one
  assign pop_room = (count <= 1);

  //----------------------------------------------------------------------
  // Queue pointers and storage
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (head_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + rd_valid - head_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      q_kind[wr_ptr] <= rd_kind;
      q_ray[wr_ptr]  <= rd_ray_id;
      q_node[wr_ptr] <= rd_node_id;
      q_tmax[wr_ptr] <= rd_t_max;
      q_tmin[wr_ptr] <= rd_t_min;
    end
  end

endmodule

`default_nettype wire

/* rtl/ss_execute.sv */
/*
  Short-stack execute stage
  Per-ray circular stack of four entries, depth, restart node and
  scene t_max tables. Applies one operation per cycle and registers
  the pop, restart or miss outcome of a leaf miss
*/
`timescale 1ns/100ps
`default_nettype none

`include "ss_params.svh"

module ss_execute import shortstack_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  ss_op_e   op,
  input  ray_id_t  op_ray_id,
  input  node_id_t op_node_id,
  input  t_val_t   op_t_max,
  output logic     rd_valid,
  output ss_res_e  rd_kind,
  output ray_id_t  rd_ray_id,
  output node_id_t rd_node_id,
  output t_val_t   rd_t_max,
  output t_val_t   rd_t_min
);

  localparam int NUM_RAYS = `SS_NUM_RAYS;
  localparam int DEPTH    = `SS_DEPTH;

  // Stack contents, payload only
  node_id_t stk_node [NUM_RAYS][DEPTH];
  t_val_t   stk_tmax [NUM_RAYS][DEPTH];

  // Per-ray control and tables
  ss_ptr_t   top_ptr    [NUM_RAYS];
  ss_depth_t depth      [NUM_RAYS];
  node_id_t  rest_node  [NUM_RAYS];
  t_val_t    scene_tmax [NUM_RAYS];

  ss_ptr_t   cur_ptr;
  ss_ptr_t   push_ptr;
  ss_depth_t cur_depth;
  t_val_t    cur_scene;
  logic      stk_empty;
  logic      stk_full;
  logic      take_restart;

  //----------------------------------------------------------------------
  // Lookup for the addressed ray
  //----------------------------------------------------------------------

  assign cur_ptr   = top_ptr[op_ray_id];
  assign cur_depth = depth[op_ray_id];
  assign cur_scene = scene_tmax[op_ray_id];
  // Slot after the top, wraps onto the oldest entry
  assign push_ptr  = cur_ptr + 1'b1;
  assign stk_empty = (cur_depth == '0);
  assign stk_full  = (cur_depth == ss_depth_t'(DEPTH));

  // Empty stack and leaf still inside the scene
  assign take_restart = stk_empty && (op_t_max < cur_scene);

  //----------------------------------------------------------------------
  // Table updates
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_RAYS; r++) begin
        top_ptr[r]    <= '0;
        depth[r]      <= '0;
        rest_node[r]  <= '0;
        scene_tmax[r] <= '0;
      end
    end else begin
      case (op)
        OP_PUSH: begin
          top_ptr[op_ray_id] <= push_ptr;
          if (!stk_full) begin
            depth[op_ray_id] <= cur_depth + 1'b1;
          end
        end
        OP_POP: begin
          if (!stk_empty) begin
            top_ptr[op_ray_id] <= cur_ptr - 1'b1;
            depth[op_ray_id]   <= cur_depth - 1'b1;
          end
        end
        OP_REST_WR:  rest_node[op_ray_id]  <= op_node_id;
        OP_SCENE_WR: scene_tmax[op_ray_id] <= op_t_max;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op == OP_PUSH) begin
      stk_node[op_ray_id][push_ptr] <= op_node_id;
      stk_tmax[op_ray_id][push_ptr] <= op_t_max;
    end
  end

  //----------------------------------------------------------------------
  // Leaf miss outcome
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= (op == OP_POP);
    end
  end

  always_ff @(posedge clk) begin
    if (op == OP_POP) begin
      rd_ray_id <= op_ray_id;
      rd_t_min  <= op_t_max;
      if (!stk_empty) begin
        rd_kind    <= RES_POP;
        rd_node_id <= stk_node[op_ray_id][cur_ptr];
        rd_t_max   <= stk_tmax[op_ray_id][cur_ptr];
      end else if (take_restart) begin
        rd_kind    <= RES_RESTART;
        rd_node_id <= rest_node[op_ray_id];
        rd_t_max   <= cur_scene;
      end else begin
        // Total miss, only the ray ID matters downstream
        rd_kind    <= RES_MISS;
        rd_node_id <= '0;
        rd_t_max   <= cur_scene;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/ss_decode.sv */
/*
  Short-stack decode stage
  Grants one input strobe per cycle by fixed priority (miss, push,
  restart write, scene write) and registers the chosen operation
*/
`timescale 1ns/100ps
`default_nettype none

module ss_decode import shortstack_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  input  ray_id_t  push_ray_id,
  input  node_id_t push_node_id,
  input  t_val_t   push_t_max,
  output logic     push_stall,
  input  logic     rest_valid,
  input  ray_id_t  rest_ray_id,
  input  node_id_t rest_node_id,
  input  t_val_t   rest_t_max,
  output logic     rest_stall,
  input  logic     scene_valid,
  input  ray_id_t  scene_ray_id,
  input  t_val_t   scene_t_max,
  output logic     scene_stall,
  input  logic     miss_valid,
  input  ray_id_t  miss_ray_id,
  input  t_val_t   miss_t_max,
  output logic     miss_stall,
  input  logic     pop_room,
  output ss_op_e   op,
  output ray_id_t  op_ray_id,
  output node_id_t op_node_id,
  output t_val_t   op_t_max
);

  logic     miss_go;
  ss_op_e   nxt_op;
  ray_id_t  nxt_ray_id;
  node_id_t nxt_node_id;
  t_val_t   nxt_t_max;

  //----------------------------------------------------------------------
  // Fixed-priority grant
  //----------------------------------------------------------------------

  // A miss only goes while the result queue can take it
  assign miss_go = miss_valid && pop_room;

  assign miss_stall  = miss_valid && !pop_room;
  assign push_stall  = push_valid && miss_go;
  assign rest_stall  = rest_valid && (miss_go || push_valid);
  assign scene_stall = scene_valid && (miss_go || push_valid || rest_valid);

  always_comb begin
    nxt_op      = OP_NONE;
    nxt_ray_id  = push_ray_id;
    nxt_node_id = push_node_id;
    nxt_t_max   = push_t_max;
    if (miss_go) begin
      nxt_op      = OP_POP;
      nxt_ray_id  = miss_ray_id;
      nxt_node_id = '0;
      // Leaf t_max, becomes t_min of the result
      nxt_t_max   = miss_t_max;
    end else if (push_valid) begin
      nxt_op = OP_PUSH;
    end else if (rest_valid) begin
      nxt_op      = OP_REST_WR;
      nxt_ray_id  = rest_ray_id;
      nxt_node_id = rest_node_id;
      nxt_t_max   = rest_t_max;
    end else if (scene_valid) begin
      nxt_op      = OP_SCENE_WR;
      nxt_ray_id  = scene_ray_id;
      nxt_node_id = '0;
      nxt_t_max   = scene_t_max;
    end
  end

  //----------------------------------------------------------------------
  // Operation register
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op <= OP_NONE;
    end else begin
      op <= nxt_op;
    end
  end

  always_ff @(posedge clk) begin
    op_ray_id  <= nxt_ray_id;
    op_node_id <= nxt_node_id;
    op_t_max   <= nxt_t_max;
  end

endmodule

`default_nettype wire

/* rtl/ss_pkg.sv */
/*
  Short-stack shared types
  Vector typedefs for IDs and distances, plus the operation and
  result kinds passed between the pipeline stages
*/
`default_nettype none

`include "ss_params.svh"

package shortstack_pkg;

  typedef logic [`SS_RAY_ID_W-1:0]  ray_id_t;
  typedef logic [`SS_NODE_ID_W-1:0] node_id_t;
  typedef logic [`SS_T_W-1:0]       t_val_t;

  // Slot index and live entry count, count reaches SS_DEPTH
  typedef logic [`SS_PTR_W-1:0] ss_ptr_t;
  typedef logic [`SS_PTR_W:0]   ss_depth_t;

  // Operation issued from decode to execute
  typedef enum logic [2:0] {
    OP_NONE,
    OP_POP,
    OP_PUSH,
    OP_REST_WR,
    OP_SCENE_WR
  } ss_op_e;

  // Outcome of a leaf miss
  typedef enum logic [1:0] {
    RES_POP,
    RES_RESTART,
    RES_MISS
  } ss_res_e;

endpackage

`default_nettype wire

/* rtl/ss_params.svh */
/*
  Short-stack unit sizing
  Widths of ray IDs, node IDs and fixed-point distances, per-ray
  stack depth and result queue depth
*/
`ifndef SS_PARAMS_SVH
`define SS_PARAMS_SVH

// Ray ID width, 16 rays
`define SS_RAY_ID_W 4
`define SS_NUM_RAYS (1 << `SS_RAY_ID_W)

// BVH node ID width
`define SS_NODE_ID_W 8

// Unsigned fixed-point distance
`define SS_T_W 16

// Entries per ray stack and its slot index width
`define SS_DEPTH 4
`define SS_PTR_W 2

// Ordered result queue toward tarb and shader
`define SS_RES_FIFO_DEPTH 4

`endif
